//--- mpf_pipe.f
hdl/mpf_pkg.sv
hdl/mpf_edge_afu.sv
hdl/mpf_rsp_order.sv
hdl/mpf_vtp.sv
hdl/mpf_pipe.sv
verification/mpf_mem_model.sv
verification/mpf_pipe_tb.sv

//--- Makefile
# Verilator build and run of the memory-properties pipeline testbench

VERILATOR ?= verilator
TOP       ?= mpf_pipe_tb
FILELIST  ?= mpf_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv) $(wildcard verification/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail if the log reports failure"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/mpf_pipe_tb.sv
// Map writes are made only while the pipe is idle, and the run stops at 200 cycles per planned request
`default_nettype none

module mpf_pipe_tb;

    import mpf_pkg::*;

    localparam int MAX_ACTIVE_REQS = 16;
    localparam int N_PAGES         = 16;
    localparam int N_RANDOM        = 200;
    localparam int N_STRESS        = 100;
    // Requests of tests 1, 2, 3, 4 and 5 in that order
    localparam int TOTAL_REQS      = 3 + 2 + N_RANDOM + N_STRESS + 5;
    localparam int TIMEOUT_CYCLES  = 200 * TOTAL_REQS;
    localparam logic [31:0] SEED   = 32'd48076;

    logic         clk;
    logic         rst;
    mpf_req_t     afu_req;
    logic         afu_req_req;
    logic         afu_req_ack;
    mpf_rsp_t     afu_rsp;
    logic         afu_rsp_req;
    logic         afu_rsp_ack;
    mpf_map_t     map;
    logic         map_valid;
    mpf_fiu_req_t fiu_req;
    logic         fiu_req_valid;
    logic         fiu_almost_full;
    mpf_fiu_rsp_t fiu_rsp;
    logic         fiu_rsp_valid;
    logic [31:0]  mem_rnd;
    logic         mem_busy;
    logic         mem_overflow;

    // Shadow page table and physical memory used by the reference
    logic [7:0]   sh_ppage [256];
    logic         sh_valid [256];
    mpf_data_t    sh_mem [65536];

    mpf_rsp_t     expected [$];
    int           errors     = 0;
    int           checked    = 0;
    int           issued     = 0;
    int           fiu_issued = 0;
    int           cycles     = 0;
    int           tests_run  = 0;
    int           tests_ok   = 0;
    logic         slow_ack   = 1'b0;
    logic [31:0]  stim_state;

    mpf_pipe
    #(
        .MAX_ACTIVE_REQS (MAX_ACTIVE_REQS),
        .N_PAGES         (N_PAGES)
    )
    u_mpf_pipe
    (
        .clk,
        .rst,
        .afu_req,
        .afu_req_req,
        .afu_req_ack,
        .afu_rsp,
        .afu_rsp_req,
        .afu_rsp_ack,
        .map,
        .map_valid,
        .fiu_req,
        .fiu_req_valid,
        .fiu_almost_full,
        .fiu_rsp,
        .fiu_rsp_valid
    );

    mpf_mem_model u_mem
    (
        .clk,
        .rst,
        .rnd      (mem_rnd),
        .busy     (mem_busy),
        .fiu_req,
        .fiu_req_valid,
        .fiu_almost_full,
        .fiu_rsp,
        .fiu_rsp_valid,
        .overflow (mem_overflow)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==============================
    // Reference and helpers
    // ==============================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected response in issue order, writes land in the shadow memory
    function automatic mpf_rsp_t predict_rsp(input mpf_req_t req);
        mpf_rsp_t   rsp;
        logic [7:0] vpage;
        mpf_paddr_t paddr;
        vpage        = req.vaddr[15:8];
        rsp.is_write = req.is_write;
        rsp.fault    = 1'b0;
        rsp.rdata    = '0;
        // Pages beyond the table size are unmapped whatever was written for them
        if (int'(vpage) >= N_PAGES || !sh_valid[vpage])
            rsp.fault = 1'b1;
        else
        begin
            paddr = {sh_ppage[vpage], req.vaddr[7:0]};
            if (req.is_write)
                sh_mem[paddr] = req.wdata;
            else
                rsp.rdata = sh_mem[paddr];
        end
        return rsp;
    endfunction

    function automatic mpf_req_t make_req(input logic is_write, input mpf_vaddr_t vaddr,
                                          input mpf_data_t wdata);
        mpf_req_t req;
        req.is_write = is_write;
        req.vaddr    = vaddr;
        req.wdata    = wdata;
        return req;
    endfunction

    function automatic mpf_req_t random_req(input logic [31:0] r, input logic [31:0] data);
        logic [7:0] vpage;
        // One in sixteen goes to a page past the table, the rest spread over 0 to 15
        if (r[15:12] == 4'h0)
            vpage = 8'd20;
        else
            vpage = {4'h0, r[4:1]};
        // Only sixteen offsets per page, so reads often hit earlier writes
        return make_req(r[0], {vpage, 4'h0, r[8:5]}, data);
    endfunction

    // Tasks below start and end 1 time unit after a rising edge
    task automatic issue_req(input mpf_req_t req);
        expected.push_back(predict_rsp(req));
        issued++;
        afu_req     = req;
        afu_req_req = 1'b1;
        while (!afu_req_ack)
        begin
            @(posedge clk);
            #1;
        end
        afu_req_req = 1'b0;
        while (afu_req_ack)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic set_map(input logic [7:0] vpage, input logic [7:0] ppage, input logic valid);
        map.vpage   = vpage;
        map.ppage   = ppage;
        map.valid   = valid;
        map_valid   = 1'b1;
        sh_ppage[vpage] = ppage;
        sh_valid[vpage] = valid;
        @(posedge clk);
        #1;
        map_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (expected.size() != 0 || afu_rsp_req || afu_rsp_ack)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        if (mem_overflow)
        begin
            $display("Memory model was sent a request beyond its slack and dropped it");
            errors++;
        end
        tests_run++;
        if (errors == errs_at_start)
        begin
            tests_ok++;
            $display("Test %s: ok", name);
        end
        else
            $display("Test %s: failed with %0d errors", name, errors - errs_at_start);
    endtask

    // ==============================
    // Response client and checker
    // ==============================

    initial
    begin : respond
        logic        req_d;
        int          delay;
        mpf_rsp_t    want;
        logic [31:0] ack_state;
        afu_rsp_ack = 1'b0;
        req_d       = 1'b0;
        delay       = 0;
        ack_state   = SEED ^ 32'h5bd1_e995;
        forever
        begin
            @(posedge clk);
            #1;
            if (afu_rsp_req && !req_d)
            begin
                if (expected.size() == 0)
                begin
                    $display("A response arrived with no request outstanding");
                    errors++;
                end
                else
                begin
                    want = expected.pop_front();
                    checked++;
                    if (afu_rsp.is_write != want.is_write)
                    begin
                        $display("Fail afu_rsp.is_write: got %h expected %h",
                                 afu_rsp.is_write, want.is_write);
                        errors++;
                    end
                    if (afu_rsp.fault != want.fault)
                    begin
                        $display("Fail afu_rsp.fault: got %h expected %h",
                                 afu_rsp.fault, want.fault);
                        errors++;
                    end
                    if (afu_rsp.rdata != want.rdata)
                    begin
                        $display("Fail afu_rsp.rdata: got %h expected %h",
                                 afu_rsp.rdata, want.rdata);
                        errors++;
                    end
                end
                ack_state = xorshift32(ack_state);
                delay = slow_ack ? int'(ack_state[3:0]) : 0;
            end
            req_d = afu_rsp_req;
            if (afu_rsp_req && !afu_rsp_ack)
            begin
                if (delay == 0)
                    afu_rsp_ack = 1'b1;
                else
                    delay--;
            end
            else if (!afu_rsp_req && afu_rsp_ack)
                afu_rsp_ack = 1'b0;
        end
    end

    // ==============================
    // Cycle counter and timeout
    // ==============================

    // Also counts FIU issues and feeds the memory model its random word
    initial
    begin : watchdog
        logic [31:0] mem_state;
        mem_state = SEED ^ 32'h9e37_79b9;
        mem_rnd   = mem_state;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (fiu_req_valid)
                fiu_issued++;
            mem_state = xorshift32(mem_state);
            mem_rnd   = mem_state;
        end
        $display("Timeout hit after %0d cycles, %0d of %0d responses still outstanding",
                 cycles, expected.size(), issued);
        $display("TESTS FAILED");
        $finish;
    end

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin : main
        int          start_err;
        int          fiu_before;
        logic [31:0] r;
        rst         = 1'b1;
        afu_req     = '0;
        afu_req_req = 1'b0;
        map         = '0;
        map_valid   = 1'b0;
        mem_busy    = 1'b0;
        stim_state  = SEED;
        for (int i = 0; i < 256; i++)
        begin
            sh_ppage[i] = '0;
            sh_valid[i] = 1'b0;
        end
        for (int i = 0; i < 65536; i++)
            sh_mem[i] = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Nothing is mapped yet, and page 0x2a is past the table anyway
        start_err  = errors;
        fiu_before = fiu_issued;
        issue_req(make_req(1'b1, 16'h0312, 32'h1234_5678));
        issue_req(make_req(1'b0, 16'h0345, 32'h0));
        issue_req(make_req(1'b0, 16'h2a10, 32'h0));
        wait_drain();
        if (fiu_issued != fiu_before)
        begin
            $display("Fail fiu_req_valid count: got %h expected %h", fiu_issued - fiu_before, 0);
            errors++;
        end
        report_test("1 unmapped fault", start_err);

        start_err = errors;
        set_map(8'd1, 8'h40, 1'b1);
        issue_req(make_req(1'b1, 16'h0120, 32'hdead_beef));
        issue_req(make_req(1'b0, 16'h0120, 32'h0));
        wait_drain();
        report_test("2 write then read", start_err);

        // Pages v and v+6 share a physical page, page 5 is unmapped again
        for (int v = 0; v < 10; v++)
            set_map(8'(v), 8'h10 + 8'(v % 6), 1'b1);
        set_map(8'd5, 8'h00, 1'b0);
        set_map(8'd20, 8'h30, 1'b1);

        start_err = errors;
        for (int i = 0; i < N_RANDOM; i++)
        begin
            stim_state = xorshift32(stim_state);
            r          = stim_state;
            stim_state = xorshift32(stim_state);
            issue_req(random_req(r, stim_state));
        end
        wait_drain();
        report_test("3 random mixed", start_err);

        start_err = errors;
        mem_busy  = 1'b1;
        slow_ack  = 1'b1;
        for (int i = 0; i < N_STRESS; i++)
        begin
            stim_state = xorshift32(stim_state);
            r          = stim_state;
            stim_state = xorshift32(stim_state);
            issue_req(random_req(r, stim_state));
        end
        wait_drain();
        mem_busy = 1'b0;
        slow_ack = 1'b0;
        report_test("4 back-pressure", start_err);

        // Page 0x50 starts empty, then gets data through page 2 and shows it through page 4
        start_err = errors;
        issue_req(make_req(1'b1, 16'h0207, 32'hcafe_0001));
        wait_drain();
        set_map(8'd2, 8'h50, 1'b1);
        issue_req(make_req(1'b0, 16'h0207, 32'h0));
        issue_req(make_req(1'b1, 16'h0207, 32'hcafe_0002));
        wait_drain();
        set_map(8'd2, 8'h12, 1'b1);
        issue_req(make_req(1'b0, 16'h0207, 32'h0));
        wait_drain();
        set_map(8'd4, 8'h50, 1'b1);
        issue_req(make_req(1'b0, 16'h0407, 32'h0));
        wait_drain();
        report_test("5 remap", start_err);

        $display("Summary: %0d of %0d tests ok, %0d responses checked, %0d errors",
                 tests_ok, tests_run, checked, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/mpf_mem_model.sv
// Memory model that does each access when a request arrives and returns responses in random order, so it holds eight requests at most
`default_nettype none

module mpf_mem_model
(
    input  wire logic                  clk,
    input  wire logic                  rst,

    // Fresh random word every cycle, supplied by the testbench
    input  wire logic [31:0]           rnd,
    // When high, almost-full is raised far more often
    input  wire logic                  busy,

    input  wire mpf_pkg::mpf_fiu_req_t fiu_req,
    input  wire logic                  fiu_req_valid,
    output logic                       fiu_almost_full,
    output mpf_pkg::mpf_fiu_rsp_t      fiu_rsp,
    output logic                       fiu_rsp_valid,

    // Set for good once a request arrives with all slots taken
    output logic                       overflow
);

    import mpf_pkg::*;

    localparam int DEPTH   = 8;
    localparam int AF_MARK = 6;

    mpf_data_t    mem [65536];
    mpf_fiu_rsp_t pend [DEPTH];
    int           count;

    initial
    begin
        for (int i = 0; i < 65536; i++)
            mem[i] = '0;
        count           = 0;
        fiu_almost_full = 1'b0;
        fiu_rsp         = '0;
        fiu_rsp_valid   = 1'b0;
        overflow        = 1'b0;
    end

    always @(posedge clk)
    begin : step
        int         n;
        logic [2:0] pick;
        if (rst)
        begin
            count = 0;
            fiu_rsp_valid   <= 1'b0;
            fiu_almost_full <= 1'b0;
            overflow        <= 1'b0;
        end
        else
        begin
            n = count;
            fiu_rsp_valid <= 1'b0;
            // Half of all cycles answer one pending request picked at random
            if (n > 0 && rnd[0])
            begin
                pick = 3'(int'(rnd[15:8]) % n);
                fiu_rsp       <= pend[pick];
                fiu_rsp_valid <= 1'b1;
                // The last entry fills the hole, order inside the list does not matter
                pend[pick] = pend[3'(n - 1)];
                n = n - 1;
            end
            // Accesses happen in arrival order, only the answers are shuffled
            if (fiu_req_valid)
            begin
                if (n == DEPTH)
                    overflow <= 1'b1;
                else
                begin
                    if (fiu_req.is_write)
                        mem[fiu_req.paddr] = fiu_req.wdata;
                    pend[3'(n)].tag      = fiu_req.tag;
                    pend[3'(n)].is_write = fiu_req.is_write;
                    pend[3'(n)].rdata    = fiu_req.is_write ? 32'h0 : mem[fiu_req.paddr];
                    n = n + 1;
                end
            end
            count = n;
            // Random stalls on top of the occupancy mark
            fiu_almost_full <= (n >= AF_MARK) ||
                               (busy ? (rnd[3:2] != 2'b00) : (rnd[6:4] == 3'b000));
        end
    end

endmodule

`default_nettype wire

//--- hdl/mpf_pipe.sv
// Memory must accept one request of slack after almost-full rises, and it must return every tag exactly once
`default_nettype none

module mpf_pipe
#(
    parameter int MAX_ACTIVE_REQS = 16,
    parameter int N_PAGES         = 16
)
(
    input  wire logic                  clk,
    input  wire logic                  rst,

    // AFU side, four-phase in both directions
    input  wire mpf_pkg::mpf_req_t     afu_req,
    input  wire logic                  afu_req_req,
    output logic                       afu_req_ack,
    output mpf_pkg::mpf_rsp_t          afu_rsp,
    output logic                       afu_rsp_req,
    input  wire logic                  afu_rsp_ack,

    // Page-table writes
    input  wire mpf_pkg::mpf_map_t     map,
    input  wire logic                  map_valid,

    // FIU side, memory-port style
    output mpf_pkg::mpf_fiu_req_t      fiu_req,
    output logic                       fiu_req_valid,
    input  wire logic                  fiu_almost_full,
    input  wire mpf_pkg::mpf_fiu_rsp_t fiu_rsp,
    input  wire logic                  fiu_rsp_valid
);

    import mpf_pkg::*;

    // Requests flow edge to ordering to translation
    mpf_req_t     edge_req;
    logic         edge_req_valid;
    logic         edge_req_ready;
    mpf_req_t     ord_req;
    mpf_tag_t     ord_tag;
    logic         ord_req_valid;
    logic         ord_req_ready;

    // Responses flow translation to ordering to edge
    mpf_fiu_rsp_t vtp_ret;
    logic         vtp_ret_fault;
    logic         vtp_ret_valid;
    mpf_rsp_t     ord_rsp;
    logic         ord_rsp_valid;
    logic         ord_rsp_ready;

    // ==============================
    // AFU edge
    // ==============================

    mpf_edge_afu edge_afu
    (
        .clk,
        .rst,
        .afu_req,
        .afu_req_req,
        .afu_req_ack,
        .afu_rsp,
        .afu_rsp_req,
        .afu_rsp_ack,
        .req_out       (edge_req),
        .req_out_valid (edge_req_valid),
        .req_out_ready (edge_req_ready),
        .rsp_in        (ord_rsp),
        .rsp_in_valid  (ord_rsp_valid),
        .rsp_in_ready  (ord_rsp_ready)
    );

    // ==============================
    // Response ordering
    // ==============================

    mpf_rsp_order
    #(
        .MAX_ACTIVE_REQS (MAX_ACTIVE_REQS)
    )
    rsp_order
    (
        .clk,
        .rst,
        .req_in        (edge_req),
        .req_in_valid  (edge_req_valid),
        .req_in_ready  (edge_req_ready),
        .req_out       (ord_req),
        .req_tag       (ord_tag),
        .req_out_valid (ord_req_valid),
        .req_out_ready (ord_req_ready),
        .ret           (vtp_ret),
        .ret_fault     (vtp_ret_fault),
        .ret_valid     (vtp_ret_valid),
        .rsp_out       (ord_rsp),
        .rsp_out_valid (ord_rsp_valid),
        .rsp_out_ready (ord_rsp_ready)
    );

    // ==============================
    // Translation and FIU register
    // ==============================

    mpf_vtp
    #(
        .N_PAGES (N_PAGES)
    )
    vtp
    (
        .clk,
        .rst,
        .map,
        .map_valid,
        .req_in        (ord_req),
        .req_tag       (ord_tag),
        .req_in_valid  (ord_req_valid),
        .req_in_ready  (ord_req_ready),
        .fiu_req,
        .fiu_req_valid,
        .fiu_almost_full,
        .fiu_rsp,
        .fiu_rsp_valid,
        .ret           (vtp_ret),
        .ret_fault     (vtp_ret_fault),
        .ret_valid     (vtp_ret_valid)
    );

endmodule

`default_nettype wire

//--- hdl/mpf_vtp.sv
// N_PAGES may be 1 to 256, virtual pages at or above it always fault, and only one fault waits at a time
`default_nettype none

module mpf_vtp
#(
    parameter int N_PAGES = 16
)
(
    input  wire logic                  clk,
    input  wire logic                  rst,

    // Page-table write port
    input  wire mpf_pkg::mpf_map_t     map,
    input  wire logic                  map_valid,

    // Tagged requests from ordering
    input  wire mpf_pkg::mpf_req_t     req_in,
    input  wire mpf_pkg::mpf_tag_t     req_tag,
    input  wire logic                  req_in_valid,
    output logic                       req_in_ready,

    // Memory request port
    output mpf_pkg::mpf_fiu_req_t      fiu_req,
    output logic                       fiu_req_valid,
    input  wire logic                  fiu_almost_full,

    // Memory responses, always accepted
    input  wire mpf_pkg::mpf_fiu_rsp_t fiu_rsp,
    input  wire logic                  fiu_rsp_valid,

    // Merged response return toward ordering
    output mpf_pkg::mpf_fiu_rsp_t      ret,
    output logic                       ret_fault,
    output logic                       ret_valid
);

    import mpf_pkg::*;

    localparam int PT_IDX_BITS = mpf_idx_bits(N_PAGES);

    logic [N_PAGES-1:0]     pt_valid;
    mpf_ppage_t             pt_ppage [N_PAGES];
    mpf_vpage_t             req_vpage;
    logic [PT_IDX_BITS-1:0] req_idx;
    logic [PT_IDX_BITS-1:0] map_idx;
    logic                   req_mapped;
    logic                   map_in_range;
    logic                   req_fire;
    logic                   fault_pending;
    logic                   fault_drain;
    mpf_tag_t               fault_tag;
    logic                   fault_is_write;

    // ==============================
    // Page table
    // ==============================

    assign map_in_range = (int'(map.vpage) < N_PAGES);
    assign map_idx      = map.vpage[PT_IDX_BITS-1:0];

    always_ff @(posedge clk)
    begin
        if (rst)
            pt_valid <= '0;
        else if (map_valid && map_in_range)
            pt_valid[map_idx] <= map.valid;
    end

    // Physical page is only looked at while its valid bit is set
    always_ff @(posedge clk)
    begin
        if (map_valid && map_in_range)
            pt_ppage[map_idx] <= map.ppage;
    end

    // ==============================
    // Translation and FIU request
    // ==============================

    assign req_vpage  = req_in.vaddr[VADDR_BITS-1:PAGE_BITS];
    assign req_idx    = req_vpage[PT_IDX_BITS-1:0];
    // Lookup sees the table before this cycle's map write
    assign req_mapped = (int'(req_vpage) < N_PAGES) && pt_valid[req_idx];

    // Issue happens next cycle, so almost-full now covers the one-cycle rule
    assign req_in_ready = !fiu_almost_full && !fault_pending;
    assign req_fire     = req_in_valid && req_in_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
            fiu_req_valid <= 1'b0;
        else
            fiu_req_valid <= req_fire && req_mapped;
    end

    // Page bits are replaced and the line offset is kept
    always_ff @(posedge clk)
    begin
        if (req_fire && req_mapped)
        begin
            fiu_req.tag      <= req_tag;
            fiu_req.is_write <= req_in.is_write;
            fiu_req.paddr    <= {pt_ppage[req_idx], req_in.vaddr[PAGE_BITS-1:0]};
            fiu_req.wdata    <= req_in.wdata;
        end
    end

    // ==============================
    // Fault path and return merge
    // ==============================

    // Memory responses win, a fault slips into the first idle cycle
    assign fault_drain = fault_pending && !fiu_rsp_valid;

    always_ff @(posedge clk)
    begin
        if (rst)
            fault_pending <= 1'b0;
        else if (req_fire && !req_mapped)
            fault_pending <= 1'b1;
        else if (fault_drain)
            fault_pending <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (req_fire && !req_mapped)
        begin
            fault_tag      <= req_tag;
            fault_is_write <= req_in.is_write;
        end
    end

    always_comb
    begin
        if (fiu_rsp_valid)
            ret = fiu_rsp;
        else
            ret = '{tag: fault_tag, is_write: fault_is_write, rdata: '0};
        ret_fault = fault_drain;
        ret_valid = fiu_rsp_valid || fault_pending;
    end

endmodule

`default_nettype wire

//--- hdl/mpf_rsp_order.sv
// MAX_ACTIVE_REQS may be 1 to 256, and every tag handed out must come back exactly once on ret
`default_nettype none

module mpf_rsp_order
#(
    parameter int MAX_ACTIVE_REQS = 16
)
(
    input  wire logic                  clk,
    input  wire logic                  rst,

    // Requests from the AFU edge
    input  wire mpf_pkg::mpf_req_t     req_in,
    input  wire logic                  req_in_valid,
    output logic                       req_in_ready,

    // Tagged requests toward translation
    output mpf_pkg::mpf_req_t          req_out,
    output mpf_pkg::mpf_tag_t          req_tag,
    output logic                       req_out_valid,
    input  wire logic                  req_out_ready,

    // Returned responses in any order, always accepted
    input  wire mpf_pkg::mpf_fiu_rsp_t ret,
    input  wire logic                  ret_fault,
    input  wire logic                  ret_valid,

    // Responses released in request order
    output mpf_pkg::mpf_rsp_t          rsp_out,
    output logic                       rsp_out_valid,
    input  wire logic                  rsp_out_ready
);

    import mpf_pkg::*;

    localparam int IDX_BITS = mpf_idx_bits(MAX_ACTIVE_REQS);

    typedef logic [IDX_BITS-1:0] idx_t;

    // Head is the oldest active slot and tail the next tag to hand out
    idx_t                       head;
    idx_t                       tail;
    idx_t                       ret_idx;
    logic [IDX_BITS:0]          active_cnt;
    logic [MAX_ACTIVE_REQS-1:0] slot_full;
    mpf_rsp_t                   slot_rsp [MAX_ACTIVE_REQS];
    logic                       tag_free;
    logic                       alloc_fire;
    logic                       rel_fire;

    // Ring step, wrapping at the slot count even when it is not a power of two
    function automatic idx_t next_idx(input idx_t i);
        return (int'(i) == MAX_ACTIVE_REQS - 1) ? '0 : i + 1'b1;
    endfunction

    // ==============================
    // Tag allocation
    // ==============================

    assign tag_free      = (active_cnt != (IDX_BITS + 1)'(MAX_ACTIVE_REQS));
    assign req_out       = req_in;
    assign req_tag       = mpf_tag_t'(tail);
    assign req_out_valid = req_in_valid && tag_free;
    assign req_in_ready  = req_out_ready && tag_free;
    assign alloc_fire    = req_in_valid && req_in_ready;

    // ==============================
    // Reorder buffer
    // ==============================

    // Tags above the ring size are never issued, so the low bits suffice
    assign ret_idx = ret.tag[IDX_BITS-1:0];

    // The head slot leaves only when its response has arrived
    assign rsp_out       = slot_rsp[head];
    assign rsp_out_valid = slot_full[head];
    assign rel_fire      = rsp_out_valid && rsp_out_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            head       <= '0;
            tail       <= '0;
            active_cnt <= '0;
            slot_full  <= '0;
        end
        else
        begin
            if (alloc_fire)
                tail <= next_idx(tail);
            if (rel_fire)
                head <= next_idx(head);
            // Both can happen in one cycle, then the count stays put
            if (alloc_fire && !rel_fire)
                active_cnt <= active_cnt + 1'b1;
            else if (rel_fire && !alloc_fire)
                active_cnt <= active_cnt - 1'b1;

            // A returning tag is never the head being released, it is already full
            if (ret_valid)
                slot_full[ret_idx] <= 1'b1;
            if (rel_fire)
                slot_full[head] <= 1'b0;
        end
    end

    // Response payload per slot
    always_ff @(posedge clk)
    begin
        if (ret_valid)
        begin
            slot_rsp[ret_idx] <= '{is_write: ret.is_write, fault: ret_fault, rdata: ret.rdata};
        end
    end

endmodule

`default_nettype wire

//--- hdl/mpf_edge_afu.sv
// Client must hold afu_req stable while afu_req_req is high, and only one response is held at a time
`default_nettype none

module mpf_edge_afu
(
    input  wire logic              clk,
    input  wire logic              rst,

    // Four-phase request port, the pipe is the slave
    input  wire mpf_pkg::mpf_req_t afu_req,
    input  wire logic              afu_req_req,
    output logic                   afu_req_ack,

    // Four-phase response port, the pipe is the master
    output mpf_pkg::mpf_rsp_t      afu_rsp,
    output logic                   afu_rsp_req,
    input  wire logic              afu_rsp_ack,

    // Internal request stream toward ordering
    output mpf_pkg::mpf_req_t      req_out,
    output logic                   req_out_valid,
    input  wire logic              req_out_ready,

    // In-order responses from ordering
    input  wire mpf_pkg::mpf_rsp_t rsp_in,
    input  wire logic              rsp_in_valid,
    output logic                   rsp_in_ready
);

    typedef enum logic {REQ_IDLE, REQ_HOLD} req_state_t;
    typedef enum logic [1:0] {RSP_IDLE, RSP_REQ, RSP_RTZ} rsp_state_t;

    req_state_t req_state;
    rsp_state_t rsp_state;

    // ==============================
    // Request slave
    // ==============================

    // The client holds the payload, so it is offered straight to the stream
    assign req_out       = afu_req;
    // Only one capture per handshake, nothing is offered while ack is still high
    assign req_out_valid = afu_req_req && (req_state == REQ_IDLE);
    assign afu_req_ack   = (req_state == REQ_HOLD);

    always_ff @(posedge clk)
    begin
        if (rst)
            req_state <= REQ_IDLE;
        else
        begin
            case (req_state)
                // Ack rises in the cycle after the stream takes the request
                REQ_IDLE:
                    if (req_out_valid && req_out_ready)
                        req_state <= REQ_HOLD;
                // Return to zero once the client drops req
                default:
                    if (!afu_req_req)
                        req_state <= REQ_IDLE;
            endcase
        end
    end

    // ==============================
    // Response master
    // ==============================

    // A new response is taken only after the previous handshake is complete
    assign rsp_in_ready = (rsp_state == RSP_IDLE);
    assign afu_rsp_req  = (rsp_state == RSP_REQ);

    always_ff @(posedge clk)
    begin
        if (rst)
            rsp_state <= RSP_IDLE;
        else
        begin
            case (rsp_state)
                RSP_IDLE:
                    if (rsp_in_valid)
                        rsp_state <= RSP_REQ;
                // The client has seen the response, so req is lowered
                RSP_REQ:
                    if (afu_rsp_ack)
                        rsp_state <= RSP_RTZ;
                // Wait for ack to fall before the next response
                default:
                    if (!afu_rsp_ack)
                        rsp_state <= RSP_IDLE;
            endcase
        end
    end

    // Response payload stays put until the return-to-zero phase is over
    always_ff @(posedge clk)
    begin
        if (rsp_in_valid && rsp_in_ready)
            afu_rsp <= rsp_in;
    end

endmodule

`default_nettype wire

//--- hdl/mpf_pkg.sv
// Address layout is fixed at 16 bits with 256-line pages and tags are 8 bits wide, so no more than 256 requests may be in flight
`default_nettype none

package mpf_pkg;

    // ==============================
    // Widths
    // ==============================

    // Page offset width, fixed by the address layout below
    localparam int PAGE_BITS  = 8;
    localparam int VADDR_BITS = 16;
    localparam int PADDR_BITS = 16;
    localparam int DATA_BITS  = 32;

    // Tags index the reorder ring, so the ring never exceeds 256 slots
    localparam int TAG_BITS   = 8;

    typedef logic [VADDR_BITS-1:0]           mpf_vaddr_t;
    typedef logic [PADDR_BITS-1:0]           mpf_paddr_t;
    typedef logic [DATA_BITS-1:0]            mpf_data_t;
    typedef logic [TAG_BITS-1:0]             mpf_tag_t;
    typedef logic [VADDR_BITS-PAGE_BITS-1:0] mpf_vpage_t;
    typedef logic [PADDR_BITS-PAGE_BITS-1:0] mpf_ppage_t;

    // ==============================
    // Request and response words
    // ==============================

    // Request as issued by the AFU, with a virtual address
    typedef struct packed {
        logic       is_write;
        mpf_vaddr_t vaddr;
        mpf_data_t  wdata;
    } mpf_req_t;

    // Response toward the AFU
    // Fault is set when the page was unmapped, and rdata is then zero
    typedef struct packed {
        logic      is_write;
        logic      fault;
        mpf_data_t rdata;
    } mpf_rsp_t;

    // One page-table write
    // Clearing valid unmaps the virtual page
    typedef struct packed {
        mpf_vpage_t vpage;
        mpf_ppage_t ppage;
        logic       valid;
    } mpf_map_t;

    // Memory-side request, already translated
    typedef struct packed {
        mpf_tag_t   tag;
        logic       is_write;
        mpf_paddr_t paddr;
        mpf_data_t  wdata;
    } mpf_fiu_req_t;

    // Memory-side response, which may come back in any order
    typedef struct packed {
        mpf_tag_t  tag;
        logic      is_write;
        mpf_data_t rdata;
    } mpf_fiu_rsp_t;

    // Index width needed to address n entries, never less than one bit
    function automatic int mpf_idx_bits(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

`default_nettype wire
